/* hdl/video_pkg.sv */
`default_nettype none

package video_pkg;

  //////////////////////////////////////////////////
  // Stream words
  //////////////////////////////////////////////////

  // One stream word, also one Y, Cr or Cb sample
  localparam int unsigned word_width = 10;

  // Timing reference preamble is 3FF, 000, 000
  localparam logic [word_width-1:0] preamble_ones = 10'h3FF;
  localparam logic [word_width-1:0] preamble_zero = 10'h000;

  // The eight legal reference code words
  localparam logic [word_width-1:0] code_sav_f0     = 10'h200;
  localparam logic [word_width-1:0] code_eav_f0     = 10'h274;
  localparam logic [word_width-1:0] code_sav_vbi_f0 = 10'h2AC;
  localparam logic [word_width-1:0] code_eav_vbi_f0 = 10'h2D8;
  localparam logic [word_width-1:0] code_sav_f1     = 10'h31C;
  localparam logic [word_width-1:0] code_eav_f1     = 10'h368;
  localparam logic [word_width-1:0] code_sav_vbi_f1 = 10'h3B0;
  localparam logic [word_width-1:0] code_eav_vbi_f1 = 10'h3C4;

  // Flag positions inside a code word
  localparam int unsigned field_bit  = 8;
  localparam int unsigned vblank_bit = 7;
  localparam int unsigned eav_bit    = 6;

  //////////////////////////////////////////////////
  // Raster
  //////////////////////////////////////////////////

  localparam int unsigned x_width = 10;
  localparam int unsigned y_width = 9;

  localparam logic [x_width-1:0] active_width  = 10'd640;
  localparam logic [y_width-1:0] active_height = 9'd480;

  // Column step per pixel, line step per end code (interlaced)
  localparam logic [x_width-1:0] column_step = 10'd1;
  localparam logic [y_width-1:0] line_step   = 9'd2;

  //////////////////////////////////////////////////
  // Packing and chroma regions
  //////////////////////////////////////////////////

  // Reduced pixel keeps the top bits of each sample
  localparam int unsigned luma_keep   = 8;
  localparam int unsigned chroma_keep = 5;
  localparam int unsigned pixel_width = luma_keep + 2 * chroma_keep;
  localparam int unsigned pair_width  = 2 * pixel_width;

  // Strict thresholds, equal values are neither high nor low
  localparam logic [word_width-1:0] chroma_high = 10'd800;
  localparam logic [word_width-1:0] chroma_low  = 10'd200;

  // Decoder states, named after the word expected next
  typedef enum logic [2:0] {
    hunt_ones,
    hunt_zero1,
    hunt_zero2,
    read_code,
    take_cb,
    take_y0,
    take_cr,
    take_y1
  } decode_state_e;

  // Corner regions, Cr named first
  typedef enum logic [1:0] {
    region_high_high = 2'd0,
    region_low_high  = 2'd1,
    region_high_low  = 2'd2,
    region_low_low   = 2'd3
  } chroma_region_e;

endpackage

`default_nettype wire

/* hdl/ccir656_decoder.sv */
`default_nettype none
`timescale 1ns/1ps

module ccir656_decoder (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [video_pkg::word_width-1:0] video_word,
  output logic                             pixel_valid,
  output logic [video_pkg::word_width-1:0] pixel_y,
  output logic [video_pkg::word_width-1:0] pixel_cr,
  output logic [video_pkg::word_width-1:0] pixel_cb,
  output logic                             code_valid,
  output logic                             code_field,
  output logic                             code_vblank,
  output logic                             code_eav
);

  video_pkg::decode_state_e state;

  // Chroma samples held until the next luma word
  logic [video_pkg::word_width-1:0] cb_hold;
  logic [video_pkg::word_width-1:0] cr_hold;

  logic is_ones;
  logic is_zero;
  logic code_ok;
  logic code_starts_line;
  logic take_luma;

  assign is_ones = (video_word == video_pkg::preamble_ones);
  assign is_zero = (video_word == video_pkg::preamble_zero);

  // Only the eight listed words count as reference codes
  always_comb
  begin
    case (video_word)
      video_pkg::code_sav_f0,
      video_pkg::code_eav_f0,
      video_pkg::code_sav_vbi_f0,
      video_pkg::code_eav_vbi_f0,
      video_pkg::code_sav_f1,
      video_pkg::code_eav_f1,
      video_pkg::code_sav_vbi_f1,
      video_pkg::code_eav_vbi_f1: code_ok = 1'b1;
      default:                    code_ok = 1'b0;
    endcase
  end

  // Start of active video outside blanking opens the sample cycle
  assign code_starts_line = code_ok && !video_word[video_pkg::vblank_bit]
                            && !video_word[video_pkg::eav_bit];

  // Luma slot, unless a new preamble breaks in
  assign take_luma = ((state == video_pkg::take_y0) || (state == video_pkg::take_y1))
                     && !is_ones;

  //////////////////////////////////////////////////
  // FSM and chroma holds
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= video_pkg::hunt_ones;
      pixel_valid <= 1'b0;
      code_valid  <= 1'b0;
      cb_hold     <= '0;
      cr_hold     <= '0;
    end
    else
    begin
      pixel_valid <= take_luma;
      code_valid  <= (state == video_pkg::read_code) && code_ok;
      case (state)
        video_pkg::hunt_ones:
          if (is_ones)
            state <= video_pkg::hunt_zero1;
        video_pkg::hunt_zero1:
          state <= is_zero ? video_pkg::hunt_zero2 :
                   is_ones ? video_pkg::hunt_zero1 : video_pkg::hunt_ones;
        video_pkg::hunt_zero2:
          state <= is_zero ? video_pkg::read_code :
                   is_ones ? video_pkg::hunt_zero1 : video_pkg::hunt_ones;
        // Blanking, end codes and bad words all go back to hunting
        video_pkg::read_code:
          state <= code_starts_line ? video_pkg::take_cb : video_pkg::hunt_ones;
        default:
        begin
          if (is_ones)
            state <= video_pkg::hunt_zero1;
          else
          begin
            case (state)
              video_pkg::take_cb:
              begin
                cb_hold <= video_word;
                state   <= video_pkg::take_y0;
              end
              video_pkg::take_y0: state <= video_pkg::take_cr;
              video_pkg::take_cr:
              begin
                cr_hold <= video_word;
                state   <= video_pkg::take_y1;
              end
              default:            state <= video_pkg::take_cb;
            endcase
          end
        end
      endcase
    end
  end

  // Samples and code flags, qualified by the valid pulses
  always_ff @(posedge clk)
  begin
    if (take_luma)
    begin
      pixel_y  <= video_word;
      pixel_cr <= cr_hold;
      pixel_cb <= cb_hold;
    end
    if (state == video_pkg::read_code)
    begin
      code_field  <= video_word[video_pkg::field_bit];
      code_vblank <= video_word[video_pkg::vblank_bit];
      code_eav    <= video_word[video_pkg::eav_bit];
    end
  end

  // A pixel and a code never share a cycle
  assert property (@(posedge clk) disable iff (reset) !(pixel_valid && code_valid))
    else $error("pixel_valid and code_valid high together");

endmodule

`default_nettype wire

/* hdl/raster_tracker.sv */
`default_nettype none
`timescale 1ns/1ps

module raster_tracker (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             pixel_valid,
  input  logic [video_pkg::word_width-1:0] pixel_y,
  input  logic [video_pkg::word_width-1:0] pixel_cr,
  input  logic [video_pkg::word_width-1:0] pixel_cb,
  input  logic                             code_valid,
  input  logic                             code_field,
  input  logic                             code_vblank,
  input  logic                             code_eav,
  output logic                             active_valid,
  output logic [video_pkg::word_width-1:0] active_y,
  output logic [video_pkg::word_width-1:0] active_cr,
  output logic [video_pkg::word_width-1:0] active_cb,
  output logic [video_pkg::x_width-1:0]    active_x,
  output logic [video_pkg::y_width-1:0]    active_line,
  output logic                             line_restart,
  output logic                             frame_start
);

  logic [video_pkg::x_width-1:0] column;
  logic [video_pkg::y_width-1:0] line;
  logic                          seen_field0;
  logic                          in_window;
  logic                          forward;

  assign in_window = (line < video_pkg::active_height) && (column < video_pkg::active_width);
  assign forward   = pixel_valid && in_window;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      column       <= '0;
      line         <= '0;
      seen_field0  <= 1'b0;
      active_valid <= 1'b0;
      line_restart <= 1'b0;
      frame_start  <= 1'b0;
    end
    else
    begin
      active_valid <= forward;
      line_restart <= code_valid && (code_vblank || code_eav);
      frame_start  <= 1'b0;
      if (code_valid)
      begin
        // Blanking restarts the field on line 0 or 1
        if (code_vblank)
        begin
          column <= '0;
          line   <= {{(video_pkg::y_width-1){1'b0}}, code_field};
        end
        else if (code_eav)
        begin
          column <= '0;
          // Stop counting past the window so the line never wraps
          if (line < video_pkg::active_height)
            line <= line + video_pkg::line_step;
        end
        // Frame begins at field 1 blanking after any field 0 code
        if (!code_field)
          seen_field0 <= 1'b1;
        else if (code_vblank && seen_field0)
        begin
          frame_start <= 1'b1;
          seen_field0 <= 1'b0;
        end
      end
      else if (forward)
        column <= column + video_pkg::column_step;
    end
  end

  always_ff @(posedge clk)
  begin
    if (forward)
    begin
      active_y    <= pixel_y;
      active_cr   <= pixel_cr;
      active_cb   <= pixel_cb;
      active_x    <= column;
      active_line <= line;
    end
  end

  // Codes win the column update, so a pixel must never arrive with a code
  assert property (@(posedge clk) disable iff (reset) !(pixel_valid && code_valid))
    else $error("pixel and code arrived in the same cycle");

endmodule

`default_nettype wire

/* hdl/pixel_pair_packer.sv */
`default_nettype none
`timescale 1ns/1ps

module pixel_pair_packer (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             active_valid,
  input  logic [video_pkg::word_width-1:0] active_y,
  input  logic [video_pkg::word_width-1:0] active_cr,
  input  logic [video_pkg::word_width-1:0] active_cb,
  input  logic [video_pkg::x_width-1:0]    active_x,
  input  logic                             line_restart,
  output logic                             pair_valid,
  output logic [video_pkg::pair_width-1:0] pair_data,
  output logic [video_pkg::x_width-1:0]    pair_x
);

  // High when the low half holds a pixel waiting for its partner
  logic                              have_first;
  logic [video_pkg::pixel_width-1:0] reduced;

  // Y then Cr then Cb, top bits only
  assign reduced = {active_y[video_pkg::word_width-1 -: video_pkg::luma_keep],
                    active_cr[video_pkg::word_width-1 -: video_pkg::chroma_keep],
                    active_cb[video_pkg::word_width-1 -: video_pkg::chroma_keep]};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      have_first <= 1'b0;
      pair_valid <= 1'b0;
    end
    else
    begin
      pair_valid <= active_valid && have_first;
      // New line drops any half-filled pair
      if (line_restart)
        have_first <= 1'b0;
      else if (active_valid)
        have_first <= !have_first;
    end
  end

  always_ff @(posedge clk)
  begin
    if (active_valid && !have_first)
    begin
      pair_data[video_pkg::pixel_width-1:0] <= reduced;
      pair_x                                <= active_x;
    end
    if (active_valid && have_first)
      pair_data[video_pkg::pair_width-1:video_pkg::pixel_width] <= reduced;
  end

endmodule

`default_nettype wire

/* hdl/chroma_classifier.sv */
`default_nettype none
`timescale 1ns/1ps

module chroma_classifier (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             active_valid,
  input  logic [video_pkg::word_width-1:0] active_cr,
  input  logic [video_pkg::word_width-1:0] active_cb,
  input  logic [video_pkg::x_width-1:0]    active_x,
  input  logic [video_pkg::y_width-1:0]    active_line,
  output logic                             hit_valid,
  output video_pkg::chroma_region_e        hit_region,
  output logic [video_pkg::x_width-1:0]    hit_x,
  output logic [video_pkg::y_width-1:0]    hit_y
);

  logic cr_high;
  logic cr_low;
  logic cb_high;
  logic cb_low;
  logic corner;
  video_pkg::chroma_region_e region;

  // Strict compares on the full samples of this pixel
  assign cr_high = active_cr > video_pkg::chroma_high;
  assign cr_low  = active_cr < video_pkg::chroma_low;
  assign cb_high = active_cb > video_pkg::chroma_high;
  assign cb_low  = active_cb < video_pkg::chroma_low;

  // Both axes must be at an extreme
  assign corner = (cr_high || cr_low) && (cb_high || cb_low);

  always_comb
  begin
    if (cr_high && cb_high)
      region = video_pkg::region_high_high;
    else if (cr_low && cb_high)
      region = video_pkg::region_low_high;
    else if (cr_high && cb_low)
      region = video_pkg::region_high_low;
    else
      region = video_pkg::region_low_low;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      hit_valid <= 1'b0;
    else
      hit_valid <= active_valid && corner;
  end

  always_ff @(posedge clk)
  begin
    if (active_valid && corner)
    begin
      hit_region <= region;
      hit_x      <= active_x;
      hit_y      <= active_line;
    end
  end

  // A hit needs an active pixel in the cycle before
  assert property (@(posedge clk) disable iff (reset) hit_valid |-> $past(active_valid))
    else $error("hit_valid without an active pixel");

endmodule

`default_nettype wire

/* hdl/video_capture.sv */
`default_nettype none
`timescale 1ns/1ps

module video_capture (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [video_pkg::word_width-1:0] video_word,
  output logic                             pair_valid,
  output logic [video_pkg::pair_width-1:0] pair_data,
  output logic [video_pkg::x_width-1:0]    pair_x,
  output logic                             hit_valid,
  output video_pkg::chroma_region_e        hit_region,
  output logic [video_pkg::x_width-1:0]    hit_x,
  output logic [video_pkg::y_width-1:0]    hit_y,
  output logic                             frame_start
);

  //////////////////////////////////////////////////
  // Decoder to tracker
  //////////////////////////////////////////////////

  logic                             pixel_valid;
  logic [video_pkg::word_width-1:0] pixel_y;
  logic [video_pkg::word_width-1:0] pixel_cr;
  logic [video_pkg::word_width-1:0] pixel_cb;
  logic                             code_valid;
  logic                             code_field;
  logic                             code_vblank;
  logic                             code_eav;

  // Tracker to packer and classifier
  logic                             active_valid;
  logic [video_pkg::word_width-1:0] active_y;
  logic [video_pkg::word_width-1:0] active_cr;
  logic [video_pkg::word_width-1:0] active_cb;
  logic [video_pkg::x_width-1:0]    active_x;
  logic [video_pkg::y_width-1:0]    active_line;
  logic                             line_restart;

  ccir656_decoder u_decoder (
    .clk         (clk),
    .reset       (reset),
    .video_word  (video_word),
    .pixel_valid (pixel_valid),
    .pixel_y     (pixel_y),
    .pixel_cr    (pixel_cr),
    .pixel_cb    (pixel_cb),
    .code_valid  (code_valid),
    .code_field  (code_field),
    .code_vblank (code_vblank),
    .code_eav    (code_eav)
  );

  raster_tracker u_tracker (
    .clk          (clk),
    .reset        (reset),
    .pixel_valid  (pixel_valid),
    .pixel_y      (pixel_y),
    .pixel_cr     (pixel_cr),
    .pixel_cb     (pixel_cb),
    .code_valid   (code_valid),
    .code_field   (code_field),
    .code_vblank  (code_vblank),
    .code_eav     (code_eav),
    .active_valid (active_valid),
    .active_y     (active_y),
    .active_cr    (active_cr),
    .active_cb    (active_cb),
    .active_x     (active_x),
    .active_line  (active_line),
    .line_restart (line_restart),
    .frame_start  (frame_start)
  );

  pixel_pair_packer u_packer (
    .clk          (clk),
    .reset        (reset),
    .active_valid (active_valid),
    .active_y     (active_y),
    .active_cr    (active_cr),
    .active_cb    (active_cb),
    .active_x     (active_x),
    .line_restart (line_restart),
    .pair_valid   (pair_valid),
    .pair_data    (pair_data),
    .pair_x       (pair_x)
  );

  chroma_classifier u_classifier (
    .clk          (clk),
    .reset        (reset),
    .active_valid (active_valid),
    .active_cr    (active_cr),
    .active_cb    (active_cb),
    .active_x     (active_x),
    .active_line  (active_line),
    .hit_valid    (hit_valid),
    .hit_region   (hit_region),
    .hit_x        (hit_x),
    .hit_y        (hit_y)
  );

endmodule

`default_nettype wire

/* test/tb_video_capture.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_video_capture;

  localparam int clk_period   = 40;
  localparam int reset_cycles = 16;
  localparam int num_fields   = 8;
  // Worst line is garbage, two codes and 700 pixels
  localparam longint words_per_line  = 1500;
  localparam longint watchdog_cycles = reset_cycles + 64
                                       + num_fields * (250 * words_per_line + 16);

  logic                             clk;
  logic                             reset;
  logic [video_pkg::word_width-1:0] video_word;
  logic                             pair_valid;
  logic [video_pkg::pair_width-1:0] pair_data;
  logic [video_pkg::x_width-1:0]    pair_x;
  logic                             hit_valid;
  video_pkg::chroma_region_e        hit_region;
  logic [video_pkg::x_width-1:0]    hit_x;
  logic [video_pkg::y_width-1:0]    hit_y;
  logic                             frame_start;

  logic [31:0] lcg_state;
  int          cycle;
  int          value_errors;
  int          event_errors;
  int          hits_seen;
  int          pairs_seen;
  int          frames_seen;
  int          frames_expected;
  logic        cur_field;

  // Reference model state, advanced once per stream word
  video_pkg::decode_state_e          model_state;
  logic [video_pkg::word_width-1:0]  model_cb;
  logic [video_pkg::word_width-1:0]  model_cr;
  int                                model_col;
  int                                model_line;
  logic                              model_seen0;
  logic                              model_half;
  logic [video_pkg::pixel_width-1:0] model_first;
  int                                model_first_x;

  // Expected events, each with the cycle it must show up in
  int                                                   hit_cycle_q[$];
  logic [1+video_pkg::x_width+video_pkg::y_width:0]     hit_info_q[$];
  int                                                   pair_cycle_q[$];
  logic [video_pkg::x_width+video_pkg::pair_width-1:0]  pair_info_q[$];
  int                                                   frame_cycle_q[$];

  video_capture DUT (
    .clk         (clk),
    .reset       (reset),
    .video_word  (video_word),
    .pair_valid  (pair_valid),
    .pair_data   (pair_data),
    .pair_x      (pair_x),
    .hit_valid   (hit_valid),
    .hit_region  (hit_region),
    .hit_x       (hit_x),
    .hit_y       (hit_y),
    .frame_start (frame_start)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Random numbers and stream words
  //////////////////////////////////////////////////

  function automatic int rand_below(input int n);
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // Upper bits, the low ones repeat too soon
    return int'(lcg_state[31:12]) % n;
  endfunction

  // Never 000 or 3FF, so samples cannot fake a preamble
  function automatic logic [video_pkg::word_width-1:0] luma_sample();
    return 10'(4 + rand_below(1016));
  endfunction

  // Biased toward the corners and the exact thresholds
  function automatic logic [video_pkg::word_width-1:0] chroma_sample();
    case (rand_below(8))
      0:       return 10'(4 + rand_below(196));
      1:       return 10'(801 + rand_below(219));
      2:       return video_pkg::chroma_low;
      3:       return video_pkg::chroma_high;
      default: return luma_sample();
    endcase
  endfunction

  function automatic logic [video_pkg::word_width-1:0] code_word(input logic field,
                                                                 input logic vblank,
                                                                 input logic eav);
    case ({field, vblank, eav})
      3'b000:  return video_pkg::code_sav_f0;
      3'b001:  return video_pkg::code_eav_f0;
      3'b010:  return video_pkg::code_sav_vbi_f0;
      3'b011:  return video_pkg::code_eav_vbi_f0;
      3'b100:  return video_pkg::code_sav_f1;
      3'b101:  return video_pkg::code_eav_f1;
      3'b110:  return video_pkg::code_sav_vbi_f1;
      default: return video_pkg::code_eav_vbi_f1;
    endcase
  endfunction

  function automatic logic is_code(input logic [video_pkg::word_width-1:0] w);
    return (w == video_pkg::code_sav_f0) || (w == video_pkg::code_eav_f0)
           || (w == video_pkg::code_sav_vbi_f0) || (w == video_pkg::code_eav_vbi_f0)
           || (w == video_pkg::code_sav_f1) || (w == video_pkg::code_eav_f1)
           || (w == video_pkg::code_sav_vbi_f1) || (w == video_pkg::code_eav_vbi_f1);
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected)
    begin
      value_errors++;
      $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  task automatic model_code(input logic field, input logic vblank, input logic eav,
                            input int stamp);
    // Blanking puts the field on line 0 or 1, end codes step by 2
    if (vblank)
    begin
      model_col  = 0;
      model_line = field;
      model_half = 1'b0;
    end
    else if (eav)
    begin
      model_col  = 0;
      model_line = model_line + 2;
      model_half = 1'b0;
    end
    if (!field)
      model_seen0 = 1'b1;
    else if (vblank && model_seen0)
    begin
      model_seen0 = 1'b0;
      frames_expected++;
      frame_cycle_q.push_back(stamp + 2);
    end
  endtask

  task automatic model_pixel(input logic [video_pkg::word_width-1:0] y, input int stamp);
    logic [video_pkg::pixel_width-1:0] reduced;
    logic                              cr_hi;
    logic                              cr_lo;
    logic                              cb_hi;
    logic                              cb_lo;
    video_pkg::chroma_region_e         region;
    if (model_line < int'(video_pkg::active_height)
        && model_col < int'(video_pkg::active_width))
    begin
      reduced = {y[9:2], model_cr[9:5], model_cb[9:5]};
      cr_hi   = model_cr > video_pkg::chroma_high;
      cr_lo   = model_cr < video_pkg::chroma_low;
      cb_hi   = model_cb > video_pkg::chroma_high;
      cb_lo   = model_cb < video_pkg::chroma_low;
      if ((cr_hi || cr_lo) && (cb_hi || cb_lo))
      begin
        if (cb_lo)
          region = cr_lo ? video_pkg::region_low_low : video_pkg::region_high_low;
        else
          region = cr_lo ? video_pkg::region_low_high : video_pkg::region_high_high;
        hit_cycle_q.push_back(stamp + 3);
        hit_info_q.push_back({region, model_col[video_pkg::x_width-1:0],
                              model_line[video_pkg::y_width-1:0]});
      end
      // First pixel waits in the low half
      if (!model_half)
      begin
        model_first   = reduced;
        model_first_x = model_col;
        model_half    = 1'b1;
      end
      else
      begin
        pair_cycle_q.push_back(stamp + 3);
        pair_info_q.push_back({model_first_x[video_pkg::x_width-1:0], reduced, model_first});
        model_half = 1'b0;
      end
      model_col++;
    end
  endtask

  task automatic model_word(input logic [video_pkg::word_width-1:0] w, input int stamp);
    logic ones;
    logic zero;
    ones = (w == video_pkg::preamble_ones);
    zero = (w == video_pkg::preamble_zero);
    case (model_state)
      video_pkg::hunt_ones:
        if (ones)
          model_state = video_pkg::hunt_zero1;
      video_pkg::hunt_zero1,
      video_pkg::hunt_zero2:
        if (ones)
          model_state = video_pkg::hunt_zero1;
        else if (!zero)
          model_state = video_pkg::hunt_ones;
        else if (model_state == video_pkg::hunt_zero1)
          model_state = video_pkg::hunt_zero2;
        else
          model_state = video_pkg::read_code;
      video_pkg::read_code:
      begin
        if (is_code(w))
          model_code(w[video_pkg::field_bit], w[video_pkg::vblank_bit],
                     w[video_pkg::eav_bit], stamp);
        // Only an active start code opens the sample cycle
        if (is_code(w) && !w[video_pkg::vblank_bit] && !w[video_pkg::eav_bit])
          model_state = video_pkg::take_cb;
        else
          model_state = video_pkg::hunt_ones;
      end
      default:
        if (ones)
          model_state = video_pkg::hunt_zero1;
        else
        begin
          case (model_state)
            video_pkg::take_cb:
            begin
              model_cb    = w;
              model_state = video_pkg::take_y0;
            end
            video_pkg::take_y0:
            begin
              model_pixel(w, stamp);
              model_state = video_pkg::take_cr;
            end
            video_pkg::take_cr:
            begin
              model_cr    = w;
              model_state = video_pkg::take_y1;
            end
            default:
            begin
              model_pixel(w, stamp);
              model_state = video_pkg::take_cb;
            end
          endcase
        end
    endcase
  endtask

  //////////////////////////////////////////////////
  // Stream generator
  //////////////////////////////////////////////////

  task automatic send_word(input logic [video_pkg::word_width-1:0] w);
    @(posedge clk);
    video_word <= w;
    model_word(w, cycle);
  endtask

  // Preamble with a chosen third word, then a code word
  task automatic send_ref(input logic [video_pkg::word_width-1:0] third,
                          input logic [video_pkg::word_width-1:0] code);
    send_word(video_pkg::preamble_ones);
    send_word(video_pkg::preamble_zero);
    send_word(third);
    send_word(code);
  endtask

  task automatic send_line();
    int                               pixels;
    int                               abort_at;
    logic [video_pkg::word_width-1:0] sav;
    sav = code_word(cur_field, 1'b0, 1'b0);
    repeat (rand_below(4))
      send_word(luma_sample());
    case (rand_below(16))
      // Damaged preamble
      0:       send_ref(luma_sample(), sav);
      // Invalid code word
      1:       send_ref(video_pkg::preamble_zero, sav ^ 10'h001);
      default: send_ref(video_pkg::preamble_zero, sav);
    endcase
    pixels   = (rand_below(16) == 0) ? 600 + rand_below(101) : rand_below(49);
    abort_at = (rand_below(10) == 0) ? rand_below(pixels + 1) : -1;
    for (int i = 0; i < pixels; i++)
    begin
      // Stray 3FF kills the rest of the line
      if (i == abort_at)
        send_word(video_pkg::preamble_ones);
      send_word(chroma_sample());
      send_word(luma_sample());
    end
    send_ref(video_pkg::preamble_zero, code_word(cur_field, 1'b0, 1'b1));
  endtask

  task automatic send_field(input int index);
    int blank_codes;
    int lines;
    // Mostly alternate fields, sometimes repeat one
    if (rand_below(4) != 0)
      cur_field = !cur_field;
    blank_codes = 1 + rand_below(3);
    repeat (blank_codes)
      send_ref(video_pkg::preamble_zero, code_word(cur_field, 1'b1, rand_below(2) == 1));
    // Some fields run past line 480
    lines = (index % 4 == 2) ? 242 + rand_below(8) : 2 + rand_below(30);
    repeat (lines)
      send_line();
  endtask

  //////////////////////////////////////////////////
  // Output monitor, sampled on the falling edge
  //////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (!reset && hit_valid !== 1'b0)
    begin
      if (hit_cycle_q.size() == 0)
      begin
        event_errors++;
        $display("Unexpected hit at time %0t", $time);
      end
      else
      begin
        hits_seen++;
        check_value("hit cycle", cycle, hit_cycle_q.pop_front());
        check_value("hit region, column and line", {hit_region, hit_x, hit_y},
                    hit_info_q.pop_front());
      end
    end
    if (!reset && pair_valid !== 1'b0)
    begin
      if (pair_cycle_q.size() == 0)
      begin
        event_errors++;
        $display("Unexpected pixel pair at time %0t", $time);
      end
      else
      begin
        pairs_seen++;
        check_value("pair cycle", cycle, pair_cycle_q.pop_front());
        check_value("pair column and data", {pair_x, pair_data}, pair_info_q.pop_front());
      end
    end
    if (!reset && frame_start !== 1'b0)
    begin
      frames_seen++;
      if (frame_cycle_q.size() == 0)
      begin
        event_errors++;
        $display("Unexpected frame start at time %0t", $time);
      end
      else
        check_value("frame start cycle", cycle, frame_cycle_q.pop_front());
    end
    cycle = cycle + 1;
  end

  initial
  begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired after %0d cycles with the stream unfinished", watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    int drain;
    reset           <= 1'b1;
    video_word      <= '0;
    lcg_state       = 32'h6233_116b;
    cycle           = 0;
    value_errors    = 0;
    event_errors    = 0;
    hits_seen       = 0;
    pairs_seen      = 0;
    frames_seen     = 0;
    frames_expected = 0;
    cur_field       = 1'b1;
    model_state     = video_pkg::hunt_ones;
    model_cb        = '0;
    model_cr        = '0;
    model_col       = 0;
    model_line      = 0;
    model_seen0     = 1'b0;
    model_half      = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    for (int f = 0; f < num_fields; f++)
      send_field(f);
    // Park the decoder in the hunt and let the pipeline empty
    send_ref(video_pkg::preamble_zero, code_word(cur_field, 1'b1, 1'b1));
    repeat (4)
      send_word(luma_sample());
    drain = 0;
    while ((hit_cycle_q.size() + pair_cycle_q.size() + frame_cycle_q.size()) != 0
           && drain < 16)
    begin
      @(negedge clk);
      drain++;
    end
    repeat (4) @(negedge clk);
    if ((hit_cycle_q.size() + pair_cycle_q.size() + frame_cycle_q.size()) != 0)
    begin
      event_errors++;
      $display("Missing %0d hits, %0d pairs and %0d frame starts at the end of the run",
               hit_cycle_q.size(), pair_cycle_q.size(), frame_cycle_q.size());
    end
    check_value("frame start count", frames_seen, frames_expected);
    $display("Pairs %0d, hits %0d, frame starts %0d, value errors %0d, event errors %0d",
             pairs_seen, hits_seen, frames_seen, value_errors, event_errors);
    if (value_errors == 0 && event_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
hdl/video_pkg.sv
hdl/ccir656_decoder.sv
hdl/raster_tracker.sv
hdl/pixel_pair_packer.sv
hdl/chroma_classifier.sv
hdl/video_capture.sv
test/tb_video_capture.sv

/* Bender.yml */
package:
  name: video_capture

sources:
  - files:
      - hdl/video_pkg.sv
      - hdl/ccir656_decoder.sv
      - hdl/raster_tracker.sv
      - hdl/pixel_pair_packer.sv
      - hdl/chroma_classifier.sv
      - hdl/video_capture.sv
  - target: test
    files:
      - test/tb_video_capture.sv
